// ==== isa_pkg.sv ====
package isa_pkg;

	// datapath and register index widths
	localparam int data_w     = 16;
	localparam int reg_addr_w = 3;

	// immediate field widths inside the instruction word
	localparam int imm6_w = 6;
	localparam int imm9_w = 9;

	typedef logic [data_w-1:0]     data_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;
	typedef logic [3:0]            opcode_t;

	// condition code in the two low bits of an R-type word
	// 11 is only meaningful for the add opcode (ADL)
	typedef enum logic [1:0] {
		cz_always   = 2'b00,
		cz_if_zero  = 2'b01,
		cz_if_carry = 2'b10,
		cz_shift    = 2'b11
	} cz_t;

	// instruction word, msb first
	// for ADI and LHI the low fields carry the immediate instead
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rc;
		logic      spare;
		cz_t       cz;
	} instr_t;

	// kept opcodes, everything else decodes as a bubble
	localparam opcode_t op_add  = 4'b0000;
	localparam opcode_t op_adi  = 4'b0001;
	localparam opcode_t op_nand = 4'b0010;
	localparam opcode_t op_lhi  = 4'b0011;
	localparam opcode_t op_nop  = 4'b0111;

	// canonical nop, opcode 0111 then zeros
	localparam instr_t nop_instr = 16'h7000;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

	// register file depth
	localparam int n_regs = 8;

	// alu function chosen at decode
	typedef enum logic [1:0] {
		alu_add,
		alu_nand,
		alu_pass_imm
	} alu_op_t;

	// source of alu operand b
	typedef enum logic [1:0] {
		src_rb,
		src_imm6,
		src_rb_shl1
	} src_b_t;

	// decode to execute payload
	// ra_data and rb_data are the register file values seen at decode,
	// execute may still replace them from the writeback slot
	typedef struct packed {
		alu_op_t           alu_op;
		src_b_t            src_b;
		isa_pkg::cz_t      cz;
		isa_pkg::reg_addr_t dest;
		isa_pkg::reg_addr_t ra_addr;
		isa_pkg::reg_addr_t rb_addr;
		isa_pkg::data_t    ra_data;
		isa_pkg::data_t    rb_data;
		// sign-extended for ADI, shifted up for LHI
		isa_pkg::data_t    imm;
		logic              writes_rd;
		logic              sets_carry;
		logic              sets_zero;
	} decode_out_t;

	// execute to writeback payload
	// write_en is already cleared for nops and failed conditions
	typedef struct packed {
		isa_pkg::reg_addr_t dest;
		isa_pkg::data_t    data;
		logic              write_en;
	} wb_t;

endpackage

// ==== pipe_stage_reg.sv ====
`timescale 1ns/1ps

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// valid bit, a cleared slot is a bubble
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// payload loads every cycle, nothing stalls
	always_ff @(posedge clk) begin
		out_data <= in_data;
	end

	// downstream qualifies the payload with this bit
	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out_valid));

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  isa_pkg::reg_addr_t rd_addr_a,
	input  isa_pkg::reg_addr_t rd_addr_b,
	output isa_pkg::data_t     rd_data_a,
	output isa_pkg::data_t     rd_data_b,
	input  pipe_pkg::wb_t      wr
);

	// eight general registers
	isa_pkg::data_t regs [pipe_pkg::n_regs];

	// single write port fed from the writeback slot
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < pipe_pkg::n_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.write_en) begin
			regs[wr.dest] <= wr.data;
		end
	end

	// read ports
	// a read of the register under write sees the new value,
	// this covers the instruction two behind the writer
	always_comb begin
		if (wr.write_en && (wr.dest == rd_addr_a)) begin
			rd_data_a = wr.data;
		end else begin
			rd_data_a = regs[rd_addr_a];
		end
		if (wr.write_en && (wr.dest == rd_addr_b)) begin
			rd_data_b = wr.data;
		end else begin
			rd_data_b = regs[rd_addr_b];
		end
	end

	// an x written here would spread through both bypass paths
	a_wr_data_known: assert property (@(posedge clk) disable iff (!rst_n)
		wr.write_en |-> !$isunknown(wr.data));

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                  in_valid,
	input  isa_pkg::instr_t       instr,
	input  isa_pkg::data_t        ra_data,
	input  isa_pkg::data_t        rb_data,
	output isa_pkg::reg_addr_t    ra_addr,
	output isa_pkg::reg_addr_t    rb_addr,
	output logic                  out_valid,
	output pipe_pkg::decode_out_t dec
);

	// ADI immediate, sign-extended from bit 5
	isa_pkg::data_t imm6_sext;
	// LHI immediate, nine bits moved to the top
	isa_pkg::data_t imm9_high;

	// register read addresses come straight from the word
	assign ra_addr = instr.ra;
	assign rb_addr = instr.rb;

	assign imm6_sext = {{(isa_pkg::data_w - isa_pkg::imm6_w){instr[isa_pkg::imm6_w-1]}},
		instr[isa_pkg::imm6_w-1:0]};
	assign imm9_high = {instr[isa_pkg::imm9_w-1:0], {(isa_pkg::data_w - isa_pkg::imm9_w){1'b0}}};

	// decode is purely combinational, valid passes through
	assign out_valid = in_valid;

	always_comb begin
		// defaults describe a bubble
		dec            = '0;
		dec.alu_op     = pipe_pkg::alu_add;
		dec.src_b      = pipe_pkg::src_rb;
		dec.cz         = isa_pkg::cz_always;
		dec.dest       = instr.rc;
		dec.ra_addr    = instr.ra;
		dec.rb_addr    = instr.rb;
		dec.ra_data    = ra_data;
		dec.rb_data    = rb_data;
		dec.imm        = '0;
		dec.writes_rd  = 1'b0;
		dec.sets_carry = 1'b0;
		dec.sets_zero  = 1'b0;

		case (instr.opcode)
			isa_pkg::op_add: begin
				// ADD, ADC, ADZ and ADL
				// ADL shifts rb and always writes
				dec.cz         = instr.cz;
				dec.src_b      = (instr.cz == isa_pkg::cz_shift) ? pipe_pkg::src_rb_shl1
					: pipe_pkg::src_rb;
				dec.writes_rd  = 1'b1;
				dec.sets_carry = 1'b1;
				dec.sets_zero  = 1'b1;
			end
			isa_pkg::op_adi: begin
				// rb = ra + imm6, low bits are immediate so cz is ignored
				dec.src_b      = pipe_pkg::src_imm6;
				dec.dest       = instr.rb;
				dec.imm        = imm6_sext;
				dec.writes_rd  = 1'b1;
				dec.sets_carry = 1'b1;
				dec.sets_zero  = 1'b1;
			end
			isa_pkg::op_nand: begin
				// NDU, NDC and NDZ, cz 11 has no nand form and stays a bubble
				if (instr.cz != isa_pkg::cz_shift) begin
					dec.alu_op    = pipe_pkg::alu_nand;
					dec.cz        = instr.cz;
					dec.writes_rd = 1'b1;
					dec.sets_zero = 1'b1;
				end
			end
			isa_pkg::op_lhi: begin
				// ra = imm9 << 7, flags untouched
				dec.alu_op    = pipe_pkg::alu_pass_imm;
				dec.dest      = instr.ra;
				dec.imm       = imm9_high;
				dec.writes_rd = 1'b1;
			end
			isa_pkg::op_nop: begin
				// explicit nop keeps the bubble defaults
				dec.writes_rd = 1'b0;
			end
			default: begin
				// unsupported opcodes behave as nop
				dec.writes_rd = 1'b0;
			end
		endcase
	end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  pipe_pkg::decode_out_t dec,
	input  pipe_pkg::wb_t         fwd,
	output logic                  out_valid,
	output pipe_pkg::wb_t         result
);

	// operands after forwarding
	isa_pkg::data_t opnd_a;
	isa_pkg::data_t rb_fwd;
	// operand b after source select
	isa_pkg::data_t opnd_b;
	// add with carry-out in the top bit
	logic [isa_pkg::data_w:0] sum;
	isa_pkg::data_t alu_res;

	// flag registers
	logic carry_q;
	logic zero_q;

	// condition check and its outcomes
	logic cond_ok;
	logic commit;
	logic suppressed;

	// forward from the writeback slot holding the instruction one ahead
	// older results were already caught by the register file bypass
	assign opnd_a = (fwd.write_en && (fwd.dest == dec.ra_addr)) ? fwd.data : dec.ra_data;
	assign rb_fwd = (fwd.write_en && (fwd.dest == dec.rb_addr)) ? fwd.data : dec.rb_data;

	// operand b select
	always_comb begin
		case (dec.src_b)
			pipe_pkg::src_imm6: begin
				opnd_b = dec.imm;
			end
			pipe_pkg::src_rb_shl1: begin
				// ADL drops bit 15 of rb
				opnd_b = {rb_fwd[isa_pkg::data_w-2:0], 1'b0};
			end
			default: begin
				opnd_b = rb_fwd;
			end
		endcase
	end

	// 17-bit add so the carry falls out of the msb
	assign sum = {1'b0, opnd_a} + {1'b0, opnd_b};

	always_comb begin
		case (dec.alu_op)
			pipe_pkg::alu_nand: begin
				alu_res = ~(opnd_a & opnd_b);
			end
			pipe_pkg::alu_pass_imm: begin
				alu_res = dec.imm;
			end
			default: begin
				alu_res = sum[isa_pkg::data_w-1:0];
			end
		endcase
	end

	// conditional execute against the flags as they stand now
	always_comb begin
		case (dec.cz)
			isa_pkg::cz_if_carry: begin
				cond_ok = carry_q;
			end
			isa_pkg::cz_if_zero: begin
				cond_ok = zero_q;
			end
			default: begin
				// plain ops and ADL
				cond_ok = 1'b1;
			end
		endcase
	end

	assign commit     = in_valid && dec.writes_rd && cond_ok;
	assign suppressed = in_valid && dec.writes_rd && !cond_ok;

	// flags move on the same edge that loads the writeback slot
	// so the next instruction in execute sees them directly
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			carry_q <= 1'b0;
			zero_q  <= 1'b0;
		end else begin
			if (commit && dec.sets_carry) begin
				carry_q <= sum[isa_pkg::data_w];
			end
			if (commit && dec.sets_zero) begin
				zero_q <= (alu_res == '0);
			end
		end
	end

	// writeback payload
	assign result.dest     = dec.dest;
	assign result.data     = alu_res;
	assign result.write_en = commit;
	assign out_valid       = in_valid;

	// only ADC, ADZ, NDC and NDZ may drop their write
	// so ADI, ADL and LHI must never arrive here with a condition
	a_suppress_cond: assert property (@(posedge clk) disable iff (!rst_n)
		suppressed |-> (dec.src_b == pipe_pkg::src_rb && dec.alu_op != pipe_pkg::alu_pass_imm));

endmodule

// ==== alu_core.sv ====
`timescale 1ns/1ps

module alu_core (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  isa_pkg::instr_t    instr,
	output logic               wb_valid,
	output isa_pkg::reg_addr_t wb_addr,
	output isa_pkg::data_t     wb_data
);

	// input slot
	logic            in_q_valid;
	isa_pkg::instr_t in_q_instr;

	// decode outputs and register file read ports
	isa_pkg::reg_addr_t    rf_ra_addr;
	isa_pkg::reg_addr_t    rf_rb_addr;
	isa_pkg::data_t        rf_ra_data;
	isa_pkg::data_t        rf_rb_data;
	logic                  dec_valid;
	pipe_pkg::decode_out_t dec_d;

	// decode to execute slot
	logic                  dx_valid;
	pipe_pkg::decode_out_t dx_q;

	// execute outputs and writeback slot
	logic          ex_valid;
	pipe_pkg::wb_t ex_result;
	logic          xw_valid;
	pipe_pkg::wb_t xw_q;
	// writeback slot gated by its valid, drives the write port and forwarding
	pipe_pkg::wb_t wb_q;

	pipe_stage_reg #(.payload_t(isa_pkg::instr_t)) s_in (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (instr_valid),
		.in_data   (instr),
		.out_valid (in_q_valid),
		.out_data  (in_q_instr)
	);

	decode_stage u_decode (
		.in_valid  (in_q_valid),
		.instr     (in_q_instr),
		.ra_data   (rf_ra_data),
		.rb_data   (rf_rb_data),
		.ra_addr   (rf_ra_addr),
		.rb_addr   (rf_rb_addr),
		.out_valid (dec_valid),
		.dec       (dec_d)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rf_ra_addr),
		.rd_addr_b (rf_rb_addr),
		.rd_data_a (rf_ra_data),
		.rd_data_b (rf_rb_data),
		.wr        (wb_q)
	);

	pipe_stage_reg #(.payload_t(pipe_pkg::decode_out_t)) s_dx (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (dec_valid),
		.in_data   (dec_d),
		.out_valid (dx_valid),
		.out_data  (dx_q)
	);

	execute_stage u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (dx_valid),
		.dec       (dx_q),
		.fwd       (wb_q),
		.out_valid (ex_valid),
		.result    (ex_result)
	);

	pipe_stage_reg #(.payload_t(pipe_pkg::wb_t)) s_xw (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (ex_valid),
		.in_data   (ex_result),
		.out_valid (xw_valid),
		.out_data  (xw_q)
	);

	// a bubble in the last slot never writes
	assign wb_q.dest     = xw_q.dest;
	assign wb_q.data     = xw_q.data;
	assign wb_q.write_en = xw_valid & xw_q.write_en;

	assign wb_valid = wb_q.write_en;
	assign wb_addr  = wb_q.dest;
	assign wb_data  = wb_q.data;

endmodule

// ==== alu_core_tb.sv ====
`timescale 1ns/1ps

module alu_core_tb;

	localparam int clk_period   = 4;
	localparam int reset_cycles = 16;
	// test lengths that the watchdog limit is derived from
	localparam int max_gap    = 3;
	localparam int n_directed = 64;
	localparam int n_noise    = 40;
	localparam int n_mix      = 500;
	localparam int drain_max  = 40;
	// each instruction may be followed by up to max_gap idle slots
	localparam int total_slots     = (n_directed + n_noise + n_mix) * (max_gap + 1);
	localparam int watchdog_cycles = reset_cycles + total_slots + drain_max + 50;

	// one register write the model expects on the wb port
	typedef struct packed {
		isa_pkg::reg_addr_t addr;
		isa_pkg::data_t     data;
		logic [31:0]        cycle;
	} exp_write_t;

	logic               clk;
	logic               rst_n;
	logic               instr_valid;
	isa_pkg::instr_t    instr;
	logic               wb_valid;
	isa_pkg::reg_addr_t wb_addr;
	isa_pkg::data_t     wb_data;

	// reference model state
	isa_pkg::data_t m_regs [pipe_pkg::n_regs];
	logic           m_carry;
	logic           m_zero;
	exp_write_t     exp_q [$];

	// counts rising edges since time zero
	logic [31:0] cycle_cnt = '0;
	int          errors;

	alu_core UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 32'd1;
	end

	// instruction word builders
	function automatic isa_pkg::instr_t rtype_word(input isa_pkg::opcode_t op,
		input isa_pkg::reg_addr_t ra, input isa_pkg::reg_addr_t rb,
		input isa_pkg::reg_addr_t rc, input isa_pkg::cz_t cz);
		return isa_pkg::instr_t'({op, ra, rb, rc, 1'b0, cz});
	endfunction

	function automatic isa_pkg::instr_t adi_word(input isa_pkg::reg_addr_t ra,
		input isa_pkg::reg_addr_t rb, input logic [5:0] imm);
		return isa_pkg::instr_t'({isa_pkg::op_adi, ra, rb, imm});
	endfunction

	function automatic isa_pkg::instr_t lhi_word(input isa_pkg::reg_addr_t ra,
		input logic [8:0] imm);
		return isa_pkg::instr_t'({isa_pkg::op_lhi, ra, imm});
	endfunction

	// any kept form, a nop or an unknown opcode
	function automatic isa_pkg::instr_t random_instr();
		int unsigned        sel;
		isa_pkg::reg_addr_t ra;
		isa_pkg::reg_addr_t rb;
		isa_pkg::reg_addr_t rc;
		sel = $urandom % 12;
		ra  = 3'($urandom);
		rb  = 3'($urandom);
		rc  = 3'($urandom);
		case (sel)
			0, 1, 2, 3: return rtype_word(isa_pkg::op_add, ra, rb, rc,
				isa_pkg::cz_t'(2'($urandom)));
			4, 5: return adi_word(ra, rb, 6'($urandom));
			6: return rtype_word(isa_pkg::op_nand, ra, rb, rc, isa_pkg::cz_always);
			7: return rtype_word(isa_pkg::op_nand, ra, rb, rc, isa_pkg::cz_if_carry);
			8: return rtype_word(isa_pkg::op_nand, ra, rb, rc, isa_pkg::cz_if_zero);
			9: return lhi_word(ra, 9'($urandom));
			10: return isa_pkg::nop_instr;
			// opcodes 4 to 15 with random low bits
			default: return isa_pkg::instr_t'({4'(4 + $urandom % 12), 12'($urandom)});
		endcase
	endfunction

	// reference model applying one instruction in issue order
	function automatic void model_step(input isa_pkg::instr_t ins, input logic [31:0] due);
		isa_pkg::data_t     a;
		isa_pkg::data_t     b;
		isa_pkg::data_t     res;
		isa_pkg::reg_addr_t dest;
		logic [16:0]        sum;
		logic               writes;
		logic               cond;
		logic               sets_c;
		logic               sets_z;
		exp_write_t         w;
		a      = m_regs[ins.ra];
		b      = m_regs[ins.rb];
		dest   = ins.rc;
		sum    = '0;
		res    = '0;
		writes = 1'b0;
		sets_c = 1'b0;
		sets_z = 1'b0;
		// conditional forms look at the flags of the last committed write
		case (ins.cz)
			isa_pkg::cz_if_carry: cond = m_carry;
			isa_pkg::cz_if_zero: cond = m_zero;
			default: cond = 1'b1;
		endcase
		case (ins.opcode)
			isa_pkg::op_add: begin
				// ADL doubles rb before the add
				if (ins.cz == isa_pkg::cz_shift)
					b = {b[14:0], 1'b0};
				sum    = {1'b0, a} + {1'b0, b};
				res    = sum[15:0];
				writes = 1'b1;
				sets_c = 1'b1;
				sets_z = 1'b1;
			end
			isa_pkg::op_adi: begin
				// low six bits are the immediate and never a condition
				cond   = 1'b1;
				dest   = ins.rb;
				sum    = {1'b0, a} + {1'b0, {{10{ins[5]}}, ins[5:0]}};
				res    = sum[15:0];
				writes = 1'b1;
				sets_c = 1'b1;
				sets_z = 1'b1;
			end
			isa_pkg::op_nand: begin
				// cz 11 has no nand form
				res    = ~(a & b);
				writes = (ins.cz != isa_pkg::cz_shift);
				sets_z = 1'b1;
			end
			isa_pkg::op_lhi: begin
				cond   = 1'b1;
				dest   = ins.ra;
				res    = {ins[8:0], 7'b0};
				writes = 1'b1;
			end
			default: writes = 1'b0;
		endcase
		if (writes && cond) begin
			m_regs[dest] = res;
			if (sets_c)
				m_carry = sum[16];
			if (sets_z)
				m_zero = (res == 16'h0000);
			w.addr  = dest;
			w.data  = res;
			w.cycle = due;
			exp_q.push_back(w);
		end
	endfunction

	task automatic issue(input isa_pkg::instr_t ins);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= ins;
		// cycle_cnt still holds the count before this edge
		// and s_in, s_dx and s_xw load on the next three edges
		model_step(ins, cycle_cnt + 32'd4);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			// junk payload under a low valid must never write
			instr <= isa_pkg::instr_t'(16'($urandom));
		end
	endtask

	// compare process samples the wb port mid-cycle
	initial begin
		exp_write_t w;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1) begin
				assert (!$isunknown(wb_valid)) else begin
					errors++;
					$display("wb_valid is unknown at %0t", $time);
				end
				if (wb_valid === 1'b1) begin
					assert (exp_q.size() > 0) else begin
						errors++;
						$display("unexpected write to r%0d at %0t, no write was pending",
							wb_addr, $time);
					end
					if (exp_q.size() > 0) begin
						w = exp_q.pop_front();
						assert (wb_addr === w.addr) else begin
							errors++;
							$display("ERR %0t wb_addr exp=%0d got=%0d", $time, w.addr, wb_addr);
						end
						assert (wb_data === w.data) else begin
							errors++;
							$display("ERR %0t wb_data exp=%h got=%h", $time, w.data, wb_data);
						end
						assert (cycle_cnt === w.cycle) else begin
							errors++;
							$display("write to r%0d came at cycle %0d instead of cycle %0d",
								wb_addr, cycle_cnt, w.cycle);
						end
					end
				end
			end
		end
	end

	// watchdog
	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout after %0d cycles, the run did not finish", watchdog_cycles);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		isa_pkg::instr_t word;
		int              waited;
		void'($urandom(32'hbb356c80));
		errors      = 0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = isa_pkg::nop_instr;
		for (int i = 0; i < pipe_pkg::n_regs; i++)
			m_regs[i] = '0;
		m_carry = 1'b0;
		m_zero  = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		// quiet period where wb_valid has to stay low
		idle_cycles(8);

		// LHI into every register
		for (int i = 0; i < pipe_pkg::n_regs; i++)
			issue(lhi_word(3'(i), 9'($urandom)));

		// dependent chain where one ahead forwards and two ahead writes through
		issue(rtype_word(isa_pkg::op_add, 3'd0, 3'd1, 3'd1, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_add, 3'd1, 3'd1, 3'd2, isa_pkg::cz_always));
		issue(adi_word(3'd2, 3'd3, 6'h3b));
		issue(rtype_word(isa_pkg::op_nand, 3'd3, 3'd2, 3'd4, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_add, 3'd4, 3'd3, 3'd5, isa_pkg::cz_always));
		issue(adi_word(3'd5, 3'd5, 6'h07));
		issue(rtype_word(isa_pkg::op_add, 3'd5, 3'd1, 3'd6, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_nand, 3'd6, 3'd6, 3'd7, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_add, 3'd7, 3'd5, 3'd0, isa_pkg::cz_always));
		issue(adi_word(3'd0, 3'd1, 6'h01));
		// one idle slot between so only the write-through covers it
		repeat (4) begin
			issue(rtype_word(isa_pkg::op_add, 3'd2, 3'd1, 3'd2, isa_pkg::cz_always));
			idle_cycles(1);
		end

		// flag driven writes with r1 and r2 holding 8000
		issue(lhi_word(3'd1, 9'h100));
		issue(lhi_word(3'd2, 9'h100));
		issue(rtype_word(isa_pkg::op_add, 3'd1, 3'd2, 3'd3, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_add, 3'd1, 3'd3, 3'd4, isa_pkg::cz_if_carry));
		issue(rtype_word(isa_pkg::op_add, 3'd4, 3'd4, 3'd5, isa_pkg::cz_if_carry));
		issue(rtype_word(isa_pkg::op_add, 3'd4, 3'd1, 3'd5, isa_pkg::cz_if_zero));
		issue(rtype_word(isa_pkg::op_nand, 3'd1, 3'd2, 3'd6, isa_pkg::cz_if_carry));
		issue(rtype_word(isa_pkg::op_nand, 3'd1, 3'd2, 3'd6, isa_pkg::cz_if_zero));
		issue(rtype_word(isa_pkg::op_add, 3'd1, 3'd1, 3'd7, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_nand, 3'd1, 3'd2, 3'd6, isa_pkg::cz_if_zero));
		issue(rtype_word(isa_pkg::op_nand, 3'd6, 3'd6, 3'd0, isa_pkg::cz_if_carry));
		issue(rtype_word(isa_pkg::op_add, 3'd0, 3'd0, 3'd0, isa_pkg::cz_if_zero));
		issue(adi_word(3'd3, 3'd4, 6'h3f));
		issue(rtype_word(isa_pkg::op_nand, 3'd4, 3'd4, 3'd5, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_add, 3'd4, 3'd4, 3'd5, isa_pkg::cz_if_zero));
		issue(rtype_word(isa_pkg::op_add, 3'd4, 3'd5, 3'd3, isa_pkg::cz_if_carry));

		// ADL and carry out of ADD and ADI seen through ADC
		issue(lhi_word(3'd1, 9'h080));
		issue(rtype_word(isa_pkg::op_add, 3'd1, 3'd1, 3'd2, isa_pkg::cz_shift));
		issue(rtype_word(isa_pkg::op_add, 3'd2, 3'd2, 3'd3, isa_pkg::cz_shift));
		issue(rtype_word(isa_pkg::op_add, 3'd3, 3'd1, 3'd4, isa_pkg::cz_if_carry));
		issue(lhi_word(3'd5, 9'h1ff));
		issue(adi_word(3'd5, 3'd6, 6'h3f));
		issue(rtype_word(isa_pkg::op_add, 3'd6, 3'd0, 3'd7, isa_pkg::cz_if_carry));
		issue(rtype_word(isa_pkg::op_add, 3'd1, 3'd1, 3'd0, isa_pkg::cz_always));
		issue(rtype_word(isa_pkg::op_add, 3'd7, 3'd7, 3'd7, isa_pkg::cz_if_carry));

		// nops and unknown opcodes with a real instruction now and then
		for (int k = 0; k < n_noise; k++) begin
			if (k % 3 == 0)
				word = random_instr();
			else if ($urandom % 2)
				word = isa_pkg::nop_instr;
			else
				word = isa_pkg::instr_t'({4'(4 + $urandom % 12), 12'($urandom)});
			issue(word);
			idle_cycles($urandom % (max_gap + 1));
		end

		// long random mix mostly issued back to back
		for (int k = 0; k < n_mix; k++) begin
			issue(random_instr());
			if ($urandom % 4 == 0)
				idle_cycles($urandom % max_gap);
		end

		// let the pipe empty and wait a few more cycles for late strobes
		waited = 0;
		while (exp_q.size() > 0 && waited < drain_max) begin
			idle_cycles(1);
			waited++;
		end
		idle_cycles(4);
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("%0d expected register writes never appeared on the wb port",
				exp_q.size());
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== alu_core.f ====
isa_pkg.sv
pipe_pkg.sv
pipe_stage_reg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
alu_core.sv
alu_core_tb.sv

// ==== Bender.yml ====
package:
  name: alu_core

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - pipe_stage_reg.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - alu_core.sv
  - target: test
    files:
      - alu_core_tb.sv
